/* core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath widths
`define CORE_WORD_W      32
`define CORE_REG_ADDR_W  5
`define CORE_NUM_REGS    32
`define CORE_IMM_W       16

// opcode field values
`define CORE_OP_RTYPE    6'b000001
`define CORE_OP_ADDI     6'b000101

// funct field values, r-type only
`define CORE_FUNCT_ADD   6'd1
`define CORE_FUNCT_SUB   6'd2
`define CORE_FUNCT_AND   6'd4
`define CORE_FUNCT_MUL   6'd8
`define CORE_FUNCT_SLT   6'd16

// latency of the multiply pipe, issue to done
`define CORE_MUL_STAGES  4

`endif

/* core_pkg.sv */
package core_pkg;

	`include "core_params.svh"

	// one data word, also the instruction word
	typedef logic [`CORE_WORD_W-1:0] word_t;

	// register number, rs / rt / rd
	typedef logic [`CORE_REG_ADDR_W-1:0] reg_addr_t;

	// instruction bits 31:26
	typedef logic [5:0] opcode_t;

	// instruction bits 5:0, r-type only
	typedef logic [5:0] funct_t;

	// operation sent to the alu pipe
	// addi travels as a plain add with the immediate on operand b
	typedef enum logic [1:0]
	{
		ALU_ADD = 2'd0, // a + b
		ALU_SUB = 2'd1, // a - b
		ALU_AND = 2'd2, // bitwise and
		ALU_SLT = 2'd3  // unsigned a < b, result 1 or 0
	} alu_op_t;

endpackage

/* register_bank.sv */
`include "core_params.svh"

module register_bank
	import core_pkg::*;
(
	input  logic      clk,
	input  reg_addr_t i_rd_addr_a,   // rs
	input  reg_addr_t i_rd_addr_b,   // rt
	output word_t     o_rd_data_a,
	output word_t     o_rd_data_b,
	input  logic      i_wr_en_alu,   // alu result stream
	input  logic      i_wr_en_mul,   // mul result stream
	input  reg_addr_t i_wr_addr_alu,
	input  reg_addr_t i_wr_addr_mul,
	input  word_t     i_wr_data_alu,
	input  word_t     i_wr_data_mul
);

	word_t mem [`CORE_NUM_REGS]; // no reset, contents survive rst

	initial
	begin
		for (int n = 0; n < `CORE_NUM_REGS; n++)
			mem[n] = word_t'(n); // reg n starts at n
	end

	// mul first, alu second so alu wins on same address
	always @(posedge clk)
	begin
		if (i_wr_en_mul)
			mem[i_wr_addr_mul] <= i_wr_data_mul;
		if (i_wr_en_alu)
			mem[i_wr_addr_alu] <= i_wr_data_alu;
	end

	// read bypass of this cycle's writes, alu checked first
	always_comb
	begin
		if (i_wr_en_alu && (i_wr_addr_alu == i_rd_addr_a))
			o_rd_data_a = i_wr_data_alu;
		else if (i_wr_en_mul && (i_wr_addr_mul == i_rd_addr_a))
			o_rd_data_a = i_wr_data_mul;
		else
			o_rd_data_a = mem[i_rd_addr_a];

		if (i_wr_en_alu && (i_wr_addr_alu == i_rd_addr_b))
			o_rd_data_b = i_wr_data_alu;
		else if (i_wr_en_mul && (i_wr_addr_mul == i_rd_addr_b))
			o_rd_data_b = i_wr_data_mul;
		else
			o_rd_data_b = mem[i_rd_addr_b];
	end

endmodule

/* instr_decode.sv */
`include "core_params.svh"

module instr_decode
	import core_pkg::*;
(
	input  logic      clk,
	input  logic      rst,          // sync, active low
	input  logic      i_inst_valid, // one-cycle strobe
	input  word_t     i_inst,
	output reg_addr_t o_rd_addr_a,  // to bank, rs
	output reg_addr_t o_rd_addr_b,  // to bank, rt
	input  word_t     i_rd_data_a,
	input  word_t     i_rd_data_b,
	output logic      o_alu_issue,
	output alu_op_t   o_alu_op,
	output logic      o_mul_issue,
	output word_t     o_op_a,
	output word_t     o_op_b,
	output reg_addr_t o_dest
);

	logic      inst_vld_q; // instruction register, like if/id
	word_t     inst_q;

	opcode_t   opcode;
	funct_t    funct;
	reg_addr_t rs, rt, rd;
	word_t     imm_zext;

	logic      alu_hit;    // goes to alu pipe
	logic      mul_hit;    // goes to mul pipe
	alu_op_t   alu_op_nxt;
	word_t     op_b_nxt;
	reg_addr_t dest_nxt;

	always_ff @(posedge clk)
	begin
		if (!rst)
			inst_vld_q <= 1'b0;
		else
			inst_vld_q <= i_inst_valid;
		inst_q <= i_inst; // payload, no reset
	end

	// field split
	assign opcode   = inst_q[31:26];
	assign rs       = inst_q[25:21];
	assign rt       = inst_q[20:16];
	assign rd       = inst_q[15:11];
	assign funct    = inst_q[5:0];
	assign imm_zext = {{(`CORE_WORD_W-`CORE_IMM_W){1'b0}}, inst_q[`CORE_IMM_W-1:0]};

	assign o_rd_addr_a = rs;
	assign o_rd_addr_b = rt;

	// classify, anything unknown issues nothing
	always_comb
	begin
		alu_hit    = 1'b0;
		mul_hit    = 1'b0;
		alu_op_nxt = ALU_ADD;
		op_b_nxt   = i_rd_data_b;
		dest_nxt   = rd; // r-type writes rd
		if (opcode == `CORE_OP_RTYPE)
		begin
			case (funct)
				`CORE_FUNCT_ADD: alu_hit = 1'b1;
				`CORE_FUNCT_SUB:
				begin
					alu_hit    = 1'b1;
					alu_op_nxt = ALU_SUB;
				end
				`CORE_FUNCT_AND:
				begin
					alu_hit    = 1'b1;
					alu_op_nxt = ALU_AND;
				end
				`CORE_FUNCT_SLT:
				begin
					alu_hit    = 1'b1;
					alu_op_nxt = ALU_SLT;
				end
				`CORE_FUNCT_MUL: mul_hit = 1'b1;
				default: ; // dropped
			endcase
		end
		else if (opcode == `CORE_OP_ADDI)
		begin
			alu_hit  = 1'b1;
			op_b_nxt = imm_zext; // zero-extended imm
			dest_nxt = rt;       // addi writes rt
		end
	end

	// issue register, one edge after the instruction register
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			o_alu_issue <= 1'b0;
			o_mul_issue <= 1'b0;
		end
		else
		begin
			o_alu_issue <= inst_vld_q && alu_hit;
			o_mul_issue <= inst_vld_q && mul_hit;
		end
		o_alu_op <= alu_op_nxt;
		o_op_a   <= i_rd_data_a;
		o_op_b   <= op_b_nxt;
		o_dest   <= dest_nxt;
	end

	// one instruction feeds at most one pipe
	a_one_pipe: assert property (@(posedge clk) disable iff (!rst)
		!(o_alu_issue && o_mul_issue));

endmodule

/* alu_pipe.sv */
module alu_pipe
	import core_pkg::*;
(
	input  logic      clk,
	input  logic      rst,      // sync, active low
	input  logic      i_issue,  // strobe from decode
	input  alu_op_t   i_op,
	input  word_t     i_op_a,
	input  word_t     i_op_b,   // rt value or imm
	input  reg_addr_t i_dest,
	output logic      o_done,   // strobe to writeback
	output reg_addr_t o_dest,
	output word_t     o_result
);

	word_t alu_out; // combinational result

	always_comb
	begin
		case (i_op)
			ALU_ADD: alu_out = i_op_a + i_op_b;
			ALU_SUB: alu_out = i_op_a - i_op_b;
			ALU_AND: alu_out = i_op_a & i_op_b;
			ALU_SLT: alu_out = (i_op_a < i_op_b) ? word_t'(1) : word_t'(0); // unsigned
			default: alu_out = '0;
		endcase
	end

	// single stage, result and dest ride with done
	always_ff @(posedge clk)
	begin
		if (!rst)
			o_done <= 1'b0;
		else
			o_done <= i_issue;
		o_dest   <= i_dest;
		o_result <= alu_out;
	end

	// each issue comes back exactly one edge later
	a_alu_latency: assert property (@(posedge clk) disable iff (!rst)
		i_issue |=> o_done);

endmodule

/* mul_pipe.sv */
`include "core_params.svh"

module mul_pipe
	import core_pkg::*;
(
	input  logic      clk,
	input  logic      rst,     // sync, active low
	input  logic      i_issue, // strobe from decode
	input  word_t     i_op_a,
	input  word_t     i_op_b,
	input  reg_addr_t i_dest,
	output logic      o_done,  // strobe to writeback
	output reg_addr_t o_dest,
	output word_t     o_result // low word of a*b
);

	localparam int HALF_W = `CORE_WORD_W / 2;
	localparam int STAGES = `CORE_MUL_STAGES;

	logic              vld_q  [1:STAGES]; // valid per stage
	reg_addr_t         dest_q [1:STAGES]; // dest per stage

	word_t             p_ll_q;  // s1: a_lo*b_lo, full width
	logic [HALF_W-1:0] p_lh_q;  // s1: a_lo*b_hi, low half only
	logic [HALF_W-1:0] p_hl_q;  // s1: a_hi*b_lo, low half only
	word_t             ll_s2_q; // s2: a_lo*b_lo carried along
	logic [HALF_W-1:0] cross_q; // s2: cross term sum
	word_t             prod_q;  // s3: full low product
	word_t             res_q;   // s4: held result

	// control chain
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			for (int s = 1; s <= STAGES; s++)
				vld_q[s] <= 1'b0;
		end
		else
		begin
			vld_q[1] <= i_issue;
			for (int s = 2; s <= STAGES; s++)
				vld_q[s] <= vld_q[s-1];
		end
		dest_q[1] <= i_dest;
		for (int s = 2; s <= STAGES; s++)
			dest_q[s] <= dest_q[s-1];
	end

	// datapath, no reset
	always_ff @(posedge clk)
	begin
		p_ll_q  <= i_op_a[HALF_W-1:0] * i_op_b[HALF_W-1:0];           // widened to word
		p_lh_q  <= i_op_a[HALF_W-1:0] * i_op_b[`CORE_WORD_W-1:HALF_W]; // truncated
		p_hl_q  <= i_op_a[`CORE_WORD_W-1:HALF_W] * i_op_b[HALF_W-1:0];
		ll_s2_q <= p_ll_q;
		cross_q <= p_lh_q + p_hl_q;                 // carry out drops off the word
		prod_q  <= ll_s2_q + {cross_q, {HALF_W{1'b0}}};
		res_q   <= prod_q;
	end

	assign o_done   = vld_q[STAGES];
	assign o_dest   = dest_q[STAGES];
	assign o_result = res_q;

	// valid chain stays clean after reset even with x on inputs
	a_vld_known: assert property (@(posedge clk) disable iff (!rst)
		!$isunknown({vld_q[1], vld_q[2], vld_q[3], vld_q[STAGES]}));

endmodule

/* result_writeback.sv */
module result_writeback
	import core_pkg::*;
(
	input  logic      clk,
	input  logic      rst,          // sync active low reset
	input  logic      i_alu_done,
	input  logic      i_mul_done,
	input  reg_addr_t i_alu_dest,
	input  reg_addr_t i_mul_dest,
	input  word_t     i_alu_result,
	input  word_t     i_mul_result,
	output logic      o_alu_valid,  // also bank write enable
	output logic      o_mul_valid,
	output reg_addr_t o_alu_reg,    // also bank write address
	output reg_addr_t o_mul_reg,
	output word_t     o_alu_data,   // also bank write data
	output word_t     o_mul_data
);

	// strobes of both streams may rise together
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			o_alu_valid <= 1'b0;
			o_mul_valid <= 1'b0;
		end
		else
		begin
			o_alu_valid <= i_alu_done;
			o_mul_valid <= i_mul_done;
		end
	end

	// payloads qualified by the strobes
	always_ff @(posedge clk)
	begin
		o_alu_reg  <= i_alu_dest;
		o_alu_data <= i_alu_result;
		o_mul_reg  <= i_mul_dest;
		o_mul_data <= i_mul_result;
	end

endmodule

/* mips_multi_pipe_core.sv */
module mips_multi_pipe_core
	import core_pkg::*;
(
	input  logic      clk,
	input  logic      rst,          // sync, active low
	input  logic      i_inst_valid, // one-cycle strobe
	input  word_t     i_inst,
	output logic      o_alu_valid,
	output logic      o_mul_valid,
	output reg_addr_t o_alu_reg,
	output reg_addr_t o_mul_reg,
	output word_t     o_alu_data,
	output word_t     o_mul_data
);

	reg_addr_t rd_addr_a, rd_addr_b;   // decode -> bank
	word_t     rd_data_a, rd_data_b;   // bank -> decode
	logic      alu_issue, mul_issue;   // decode -> pipes
	alu_op_t   alu_op;
	word_t     op_a, op_b;
	reg_addr_t dest;
	logic      alu_done, mul_done;     // pipes -> writeback
	reg_addr_t alu_dest, mul_dest;
	word_t     alu_result, mul_result;

	register_bank register_bank_inst (
		.clk(clk), .i_rd_addr_a(rd_addr_a), .i_rd_addr_b(rd_addr_b),
		.o_rd_data_a(rd_data_a), .o_rd_data_b(rd_data_b),
		.i_wr_en_alu(o_alu_valid), .i_wr_en_mul(o_mul_valid),
		.i_wr_addr_alu(o_alu_reg), .i_wr_addr_mul(o_mul_reg),
		.i_wr_data_alu(o_alu_data), .i_wr_data_mul(o_mul_data));

	instr_decode instr_decode_inst (
		.clk(clk), .rst(rst), .i_inst_valid(i_inst_valid), .i_inst(i_inst),
		.o_rd_addr_a(rd_addr_a), .o_rd_addr_b(rd_addr_b),
		.i_rd_data_a(rd_data_a), .i_rd_data_b(rd_data_b),
		.o_alu_issue(alu_issue), .o_alu_op(alu_op), .o_mul_issue(mul_issue),
		.o_op_a(op_a), .o_op_b(op_b), .o_dest(dest));

	alu_pipe alu_pipe_inst (
		.clk(clk), .rst(rst), .i_issue(alu_issue), .i_op(alu_op),
		.i_op_a(op_a), .i_op_b(op_b), .i_dest(dest),
		.o_done(alu_done), .o_dest(alu_dest), .o_result(alu_result));

	mul_pipe mul_pipe_inst (
		.clk(clk), .rst(rst), .i_issue(mul_issue),
		.i_op_a(op_a), .i_op_b(op_b), .i_dest(dest),
		.o_done(mul_done), .o_dest(mul_dest), .o_result(mul_result));

	result_writeback result_writeback_inst (
		.clk(clk), .rst(rst), .i_alu_done(alu_done), .i_mul_done(mul_done),
		.i_alu_dest(alu_dest), .i_mul_dest(mul_dest),
		.i_alu_result(alu_result), .i_mul_result(mul_result),
		.o_alu_valid(o_alu_valid), .o_mul_valid(o_mul_valid),
		.o_alu_reg(o_alu_reg), .o_mul_reg(o_mul_reg),
		.o_alu_data(o_alu_data), .o_mul_data(o_mul_data));

endmodule

/* tb_core_checks.svh */
`ifndef TB_CORE_CHECKS_SVH
`define TB_CORE_CHECKS_SVH

localparam int PIPE_NONE = 0; // dropped, no result
localparam int PIPE_ALU  = 1;
localparam int PIPE_MUL  = 2;

typedef struct packed
{
	reg_addr_t dest;
	word_t     data;
} exp_rec_t; // one expected result

function automatic word_t enc_rtype(funct_t fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd);
	return {`CORE_OP_RTYPE, rs, rt, rd, 5'd0, fn}; // shamt unused
endfunction

function automatic word_t enc_itype(opcode_t op, reg_addr_t rs, reg_addr_t rt,
	logic [`CORE_IMM_W-1:0] imm);
	return {op, rs, rt, imm};
endfunction

// which result stream an instruction ends up on
function automatic int target_pipe(word_t inst);
	if (inst[31:26] == `CORE_OP_ADDI)
		return PIPE_ALU;
	if (inst[31:26] != `CORE_OP_RTYPE)
		return PIPE_NONE;
	case (inst[5:0])
		`CORE_FUNCT_ADD, `CORE_FUNCT_SUB, `CORE_FUNCT_AND, `CORE_FUNCT_SLT: return PIPE_ALU;
		`CORE_FUNCT_MUL: return PIPE_MUL;
		default: return PIPE_NONE;
	endcase
endfunction

function automatic reg_addr_t dest_of(word_t inst);
	return (inst[31:26] == `CORE_OP_ADDI) ? inst[20:16] : inst[15:11]; // addi -> rt
endfunction

// expected word for one instruction
function automatic word_t ref_result(opcode_t op, funct_t fn, word_t a, word_t b,
	logic [`CORE_IMM_W-1:0] imm);
	logic [2*`CORE_WORD_W-1:0] prod;
	prod = {{`CORE_WORD_W{1'b0}}, a} * {{`CORE_WORD_W{1'b0}}, b}; // full 64-bit product
	if (op == `CORE_OP_ADDI)
		return a + {{(`CORE_WORD_W-`CORE_IMM_W){1'b0}}, imm}; // zero-extended imm
	case (fn)
		`CORE_FUNCT_ADD: return a + b;
		`CORE_FUNCT_SUB: return a - b;
		`CORE_FUNCT_AND: return a & b;
		`CORE_FUNCT_SLT: return (a < b) ? word_t'(1) : word_t'(0); // unsigned compare
		`CORE_FUNCT_MUL: return prod[`CORE_WORD_W-1:0]; // low word only
		default: return '0;
	endcase
endfunction

// random instruction from the kept set, mul and addi drawn a bit more often
function automatic word_t random_inst(word_t r);
	funct_t fn;
	case (r[2:0])
		3'd0: fn = `CORE_FUNCT_ADD;
		3'd1: fn = `CORE_FUNCT_SUB;
		3'd2: fn = `CORE_FUNCT_AND;
		3'd3: fn = `CORE_FUNCT_SLT;
		3'd4, 3'd5: fn = `CORE_FUNCT_MUL;
		default: return enc_itype(`CORE_OP_ADDI, r[7:3], r[12:8], r[31:16]);
	endcase
	return enc_rtype(fn, r[7:3], r[12:8], r[17:13]);
endfunction

task automatic check_word(input string name, input word_t got, input word_t exp);
	if (got !== exp)
	begin
		$display("FAILED at time %0t: %s = %h, expected %h", $time, name, got, exp);
		abort_run();
	end
endtask

task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
	if (got !== exp)
	begin
		$display("FAILED at time %0t: %s = %0d, expected %0d", $time, name, got, exp);
		abort_run();
	end
endtask

`endif

/* tb_core.sv */
`include "core_params.svh"

module tb_core
	import core_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ns;

	`include "tb_core_checks.svh"

	localparam int CLK_PERIOD    = 100;
	localparam int RESET_CYCLES  = 10;
	localparam int HAZARD_CYCLES = 7;  // issue to bank write of a mul
	localparam int N_DIRECTED    = 22;
	localparam int N_RANDOM      = 300;
	localparam int SLOT_BUDGET   = 10; // worst case cycles per instruction with waits and bubbles
	localparam int DRAIN_CYCLES  = 20;
	localparam int WATCHDOG_NS   = ((N_DIRECTED + N_RANDOM) * SLOT_BUDGET + RESET_CYCLES
		+ 2 * DRAIN_CYCLES + 20) * CLK_PERIOD;

	logic      clk = 1'b0;
	logic      rst;          // active low
	logic      i_inst_valid;
	word_t     i_inst;
	logic      o_alu_valid, o_mul_valid;
	reg_addr_t o_alu_reg, o_mul_reg;
	word_t     o_alu_data, o_mul_data;

	integer    seed = 32'hcc30;
	bit        armed = 1'b0;                // set after the first reset edge
	word_t     model_regs [`CORE_NUM_REGS]; // architectural state at issue time
	int        pend [`CORE_NUM_REGS];       // cycles until a write lands
	exp_rec_t  alu_q [$];
	exp_rec_t  mul_q [$];

	mips_multi_pipe_core mips_multi_pipe_core_inst (
		.clk(clk), .rst(rst), .i_inst_valid(i_inst_valid), .i_inst(i_inst),
		.o_alu_valid(o_alu_valid), .o_mul_valid(o_mul_valid),
		.o_alu_reg(o_alu_reg), .o_mul_reg(o_mul_reg),
		.o_alu_data(o_alu_data), .o_mul_data(o_mul_data));

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1, "stopped on first error");
	endtask

	task automatic next_cycle();
		@(posedge clk);
		for (int r = 0; r < `CORE_NUM_REGS; r++)
			if (pend[r] > 0)
				pend[r]--;
	endtask

	task automatic drive_bubble();
		next_cycle();
		i_inst_valid <= 1'b0;
		i_inst       <= word_t'($random(seed)); // garbage that must be ignored
	endtask

	// reads or writes a register whose result is still on its way
	function automatic bit is_blocked(input word_t inst);
		if (target_pipe(inst) == PIPE_NONE)
			return 1'b0;
		return (pend[inst[25:21]] != 0) || (pend[inst[20:16]] != 0) || (pend[dest_of(inst)] != 0);
	endfunction

	task automatic record_issue(input word_t inst);
		exp_rec_t rec;
		int       pipe;
		pipe = target_pipe(inst);
		if (pipe != PIPE_NONE)
		begin
			rec.dest = dest_of(inst);
			rec.data = ref_result(inst[31:26], inst[5:0], model_regs[inst[25:21]],
				model_regs[inst[20:16]], inst[15:0]);
			if (pipe == PIPE_ALU)
				alu_q.push_back(rec);
			else
				mul_q.push_back(rec);
			model_regs[rec.dest] = rec.data;
			pend[rec.dest]       = HAZARD_CYCLES;
		end
	endtask

	// bubbles until the operands are settled and then one strobe
	task automatic send_inst(input word_t inst);
		bit sent;
		sent = 1'b0;
		while (!sent)
		begin
			next_cycle();
			if (is_blocked(inst))
			begin
				i_inst_valid <= 1'b0;
				i_inst       <= word_t'($random(seed));
			end
			else
			begin
				i_inst_valid <= 1'b1;
				i_inst       <= inst;
				record_issue(inst);
				sent = 1'b1;
			end
		end
	endtask

	task automatic take_result(input int pipe, input reg_addr_t r, input word_t d);
		exp_rec_t rec;
		string    tag;
		int       left;
		tag  = (pipe == PIPE_ALU) ? "o_alu" : "o_mul";
		left = (pipe == PIPE_ALU) ? alu_q.size() : mul_q.size();
		if (left == 0)
		begin
			$display("unexpected result on %s_valid at time %0t, nothing was issued", tag, $time);
			abort_run();
		end
		else
		begin
			if (pipe == PIPE_ALU)
				rec = alu_q.pop_front();
			else
				rec = mul_q.pop_front();
			check_reg({tag, "_reg"}, r, rec.dest);
			check_word({tag, "_data"}, d, rec.data);
		end
	endtask

	// outputs are settled at the falling edge
	always @(negedge clk)
	begin
		if (armed && !rst && (o_alu_valid !== 1'b0 || o_mul_valid !== 1'b0))
		begin
			$display("result strobe not low during reset at time %0t", $time);
			abort_run();
		end
		else if (armed && rst)
		begin
			if ($isunknown({o_alu_valid, o_mul_valid}))
			begin
				$display("result strobe unknown after reset at time %0t", $time);
				abort_run();
			end
			else
			begin
				if (o_alu_valid)
					take_result(PIPE_ALU, o_alu_reg, o_alu_data);
				if (o_mul_valid)
					take_result(PIPE_MUL, o_mul_reg, o_mul_data);
			end
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired at time %0t, the run did not finish", $time);
		abort_run();
	end

	initial
	begin
		word_t rnd;
		int    wait_cnt;
		rst          = 1'b0;
		i_inst_valid = 1'b0;
		i_inst       = '0;
		for (int n = 0; n < `CORE_NUM_REGS; n++)
		begin
			model_regs[n] = word_t'(n); // bank starts with reg n = n
			pend[n]       = 0;
		end
		@(posedge clk);
		armed = 1'b1;
		repeat (RESET_CYCLES - 1) @(posedge clk);
		rst <= 1'b1;
		repeat (6) drive_bubble(); // idle and no strobe may rise

		send_inst(enc_rtype(`CORE_FUNCT_ADD, 5'd7, 5'd9, 5'd10));   // first read of 7 + 9
		send_inst(enc_rtype(`CORE_FUNCT_SUB, 5'd20, 5'd3, 5'd11));
		send_inst(enc_rtype(`CORE_FUNCT_AND, 5'd13, 5'd14, 5'd12));
		send_inst(enc_rtype(`CORE_FUNCT_SLT, 5'd2, 5'd5, 5'd13));   // true
		send_inst(enc_rtype(`CORE_FUNCT_SLT, 5'd30, 5'd4, 5'd15));  // false
		send_inst(enc_itype(`CORE_OP_ADDI, 5'd1, 5'd16, 16'hffff)); // dest is rt
		send_inst(enc_itype(`CORE_OP_ADDI, 5'd0, 5'd17, 16'h8001));

		send_inst(enc_rtype(`CORE_FUNCT_MUL, 5'd16, 5'd17, 5'd18)); // wide operands
		send_inst(enc_rtype(`CORE_FUNCT_MUL, 5'd6, 5'd8, 5'd19));   // back to back
		send_inst(enc_rtype(`CORE_FUNCT_MUL, 5'd24, 5'd25, 5'd23));
		send_inst(enc_rtype(`CORE_FUNCT_MUL, 5'd27, 5'd28, 5'd26));
		send_inst(enc_rtype(`CORE_FUNCT_MUL, 5'd18, 5'd17, 5'd22)); // product past 32 bits

		send_inst(enc_itype(6'b000100, 5'd1, 5'd2, 16'h0004));      // beq
		send_inst(enc_itype(6'b100011, 5'd3, 5'd4, 16'h0010));      // lw
		send_inst(enc_itype(6'b101011, 5'd5, 5'd6, 16'h0020));      // sw
		send_inst('0);                                             // nop
		send_inst(enc_rtype(6'd32, 5'd1, 5'd2, 5'd3));              // unknown funct
		send_inst(enc_rtype(6'd3, 5'd4, 5'd5, 5'd6));

		send_inst(enc_rtype(`CORE_FUNCT_ADD, 5'd10, 5'd11, 5'd1));  // reads alu results
		send_inst(enc_rtype(`CORE_FUNCT_SUB, 5'd19, 5'd1, 5'd2));   // mul result and r1
		send_inst(enc_rtype(`CORE_FUNCT_MUL, 5'd2, 5'd21, 5'd3));
		send_inst(enc_itype(`CORE_OP_ADDI, 5'd3, 5'd4, 16'h0005));

		for (int i = 0; i < N_RANDOM; i++)
		begin
			rnd = word_t'($random(seed));
			if (rnd[31:30] == 2'b00)
				drive_bubble(); // extra gap now and then
			send_inst(random_inst(word_t'($random(seed))));
		end

		wait_cnt = 0;
		while ((alu_q.size() != 0 || mul_q.size() != 0) && wait_cnt < DRAIN_CYCLES)
		begin
			drive_bubble();
			wait_cnt++;
		end
		repeat (DRAIN_CYCLES) drive_bubble(); // catch stray results
		if (alu_q.size() == 0 && mul_q.size() == 0)
		begin
			$display("Testbench passed");
			$finish;
		end
		else
		begin
			$display("%0d alu and %0d mul results never arrived", alu_q.size(), mul_q.size());
			abort_run();
		end
	end

endmodule

/* sources.f */
+incdir+.
core_pkg.sv
register_bank.sv
instr_decode.sv
alu_pipe.sv
mul_pipe.sv
result_writeback.sv
mips_multi_pipe_core.sv
tb_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the core testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
	-f sources.f --top-module tb_core -o sim_tb_core

./obj_dir/sim_tb_core > sim.log 2>&1 || true
cat sim.log

if grep -qx "Testbench passed" sim.log; then
	echo "simulation result: pass"
	exit 0
else
	echo "simulation result: fail"
	exit 1
fi
